/* files.f */
+incdir+verif
design/periph_pkg.sv
design/periph_req_fifo.sv
design/periph_decode.sv
design/periph_timer.sv
design/periph_plic.sv
design/periph_top.sv
verif/tb_periph_top.sv

/* verif/periph_model.svh */
    // ----------------------------------------
    // shadow register state
    // ----------------------------------------
    prio_t             sh_prio [NumSrc];
    logic [NumSrc-1:0] sh_enable;
    prio_t             sh_threshold;
    logic [NumSrc-1:0] sh_service;
    logic              sh_tmr_en [NumTimers];
    data_t             sh_cmp    [NumTimers];

    function automatic void model_reset();
        for (int i = 0; i < NumSrc; i++) begin
            sh_prio[i] = '0;
        end
        for (int t = 0; t < NumTimers; t++) begin
            sh_tmr_en[t] = 1'b0;
            sh_cmp[t]    = '0;
        end
        sh_enable    = '0;
        sh_threshold = '0;
        sh_service   = '0;
    endfunction

    // id of the source a claim should return, 0 when none qualifies
    function automatic int claim_winner(input logic [NumSrc-1:0] src);
        prio_t best;
        int    id;
        best = '0;
        id   = 0;
        for (int i = 0; i < NumSrc; i++) begin
            // priority 0 never beats the threshold
            if (src[i] && sh_enable[i] && !sh_service[i] && sh_prio[i] > sh_threshold
                && sh_prio[i] > best) begin
                best = sh_prio[i];
                id   = i + 1;
            end
        end
        return id;
    endfunction

    // expected response of one access, updating the shadow copy
    function automatic data_t model_access(input addr_t addr, input logic write,
                                           input data_t wdata,
                                           input logic [NumSrc-1:0] src,
                                           output logic err);
        region_t region;
        off_t    off;
        data_t   rd;
        int      id;
        int      grp;
        region = addr[AddrWidth-1:OffWidth];
        off    = addr[OffWidth-1:0];
        err    = 1'b0;
        rd     = '0;
        grp    = off / TimerStride;
        if (region != RegionPlic && region != RegionTimer) begin
            err = 1'b1;
            return ErrData;
        end
        if (region == RegionPlic) begin
            for (int i = 0; i < NumSrc; i++) begin
                if (off == OffPrioBase + 4 * i) begin
                    if (write) begin
                        sh_prio[i] = wdata[PrioWidth-1:0];
                    end
                    rd = data_t'(sh_prio[i]);
                end
            end
            case (off)
                OffPending: begin
                    rd = data_t'(src);
                end
                OffEnable: begin
                    if (write) begin
                        sh_enable = wdata[NumSrc-1:0];
                    end
                    rd = data_t'(sh_enable);
                end
                OffThreshold: begin
                    if (write) begin
                        sh_threshold = wdata[PrioWidth-1:0];
                    end
                    rd = data_t'(sh_threshold);
                end
                OffClaim: begin
                    if (write) begin
                        if (wdata >= 1 && wdata <= NumSrc) begin
                            sh_service[wdata - 1] = 1'b0;
                        end
                    end else begin
                        id = claim_winner(src);
                        if (id != 0) begin
                            sh_service[id - 1] = 1'b1;
                        end
                        rd = data_t'(id);
                    end
                end
                default: ;
            endcase
        end else if (grp < NumTimers) begin
            case (off % TimerStride)
                OffCtrl: begin
                    if (write) begin
                        sh_tmr_en[grp] = wdata[0];
                    end
                    rd = data_t'(sh_tmr_en[grp]);
                end
                OffCompare: begin
                    if (write) begin
                        sh_cmp[grp] = wdata;
                    end
                    rd = sh_cmp[grp];
                end
                // running count is not predicted
                default: rd = '0;
            endcase
        end
        if (write) begin
            rd = '0;
        end
        return rd;
    endfunction

/* verif/tb_periph_top.sv */
`timescale 1ns/1ns

module tb_periph_top
    import periph_pkg::*;
();

    localparam int ReqDepth  = 2;
    localparam int NumTimers = 2;
    localparam int NumExtIrq = 2;
    localparam int NumSrc    = NumTimers + NumExtIrq;

    logic                 clk_i;
    logic                 rst_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    addr_t                req_addr_i;
    logic                 req_write_i;
    data_t                req_wdata_i;
    logic                 rsp_valid_o;
    logic                 rsp_ready_i;
    data_t                rsp_rdata_o;
    logic                 rsp_err_o;
    logic [NumExtIrq-1:0] ext_irq_i;
    logic                 irq_o;

    // expected timer irq levels, set by the sequence
    logic [NumTimers-1:0] tmr_lvl;

    data_t exp_data_q [$];
    logic  exp_err_q  [$];
    string exp_name_q [$];

    string test_name;
    int    acc_cnt;
    int    rsp_cnt;
    int    checks;
    int    value_errs;
    int    other_errs;
    logic  seen_full;

    `include "periph_model.svh"

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    periph_top #(
        .ReqDepth  ( ReqDepth  ),
        .NumTimers ( NumTimers ),
        .NumExtIrq ( NumExtIrq )
    ) periph_top_inst (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .req_valid_i ( req_valid_i ),
        .req_ready_o ( req_ready_o ),
        .req_addr_i  ( req_addr_i  ),
        .req_write_i ( req_write_i ),
        .req_wdata_i ( req_wdata_i ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_ready_i ( rsp_ready_i ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .rsp_err_o   ( rsp_err_o   ),
        .ext_irq_i   ( ext_irq_i   ),
        .irq_o       ( irq_o       )
    );

    // ----------------------------------------
    // handshake monitor and response checker
    // ----------------------------------------
    always @(posedge clk_i) begin : rsp_check
        data_t exp_data;
        logic  exp_err;
        string name;
        if (!rst_i) begin
            // fifo full plus a held response
            if (!rsp_ready_i && acc_cnt - rsp_cnt == 3) begin
                checks++;
                if (req_ready_o) begin
                    other_errs++;
                    $display("req_ready_o stayed high with 3 requests outstanding");
                end else begin
                    seen_full = 1'b1;
                end
            end
            if (req_valid_i && req_ready_o) begin
                acc_cnt++;
            end
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_cnt++;
                if (exp_data_q.size() == 0) begin
                    other_errs++;
                    $display("a response arrived with no request waiting for it");
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_err  = exp_err_q.pop_front();
                    name     = exp_name_q.pop_front();
                    checks += 2;
                    if (rsp_rdata_o !== exp_data) begin
                        value_errs++;
                        $display("error %s rdata: expected %h, actual %h",
                                 name, exp_data, rsp_rdata_o);
                    end
                    if (rsp_err_o !== exp_err) begin
                        value_errs++;
                        $display("error %s err: expected %0b, actual %0b",
                                 name, exp_err, rsp_err_o);
                    end
                end
            end
        end
    end

    function automatic addr_t plic_addr(input int off);
        return {RegionPlic, off_t'(off)};
    endfunction

    function automatic addr_t timer_addr(input int t, input int word);
        return {RegionTimer, off_t'(t * TimerStride + word)};
    endfunction

    task automatic print_summary();
        $display("summary: %0d checks, %0d value errors, %0d other errors",
                 checks, value_errs, other_errs);
    endtask

    task automatic stop_on_timeout(input string what);
        other_errs++;
        $display("timeout: %s", what);
        print_summary();
        $display("Finished with errors");
        $finish;
    endtask

    task automatic send_req(input addr_t addr, input logic write, input data_t wdata);
        data_t exp_data;
        logic  exp_err;
        int    waited;
        @(negedge clk_i);
        exp_data = model_access(addr, write, wdata, {ext_irq_i, tmr_lvl}, exp_err);
        exp_data_q.push_back(exp_data);
        exp_err_q.push_back(exp_err);
        exp_name_q.push_back(test_name);
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_write_i = write;
        req_wdata_i = wdata;
        waited = 0;
        @(posedge clk_i);
        while (!req_ready_o) begin
            if (waited == 100) begin
                stop_on_timeout("a request was never accepted");
            end
            waited++;
            @(posedge clk_i);
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (exp_data_q.size() != 0) begin
            if (waited == 200) begin
                stop_on_timeout("responses did not arrive");
            end
            waited++;
            @(negedge clk_i);
        end
    endtask

    task automatic single_access(input addr_t addr, input logic write, input data_t wdata);
        send_req(addr, write, wdata);
        wait_responses();
    endtask

    task automatic wait_for_irq();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!irq_o) begin
            if (waited == 100) begin
                stop_on_timeout("irq_o never rose");
            end
            waited++;
            @(negedge clk_i);
        end
    endtask

    task automatic expect_irq(input logic exp);
        @(negedge clk_i);
        checks++;
        if (irq_o !== exp) begin
            value_errs++;
            $display("error %s irq_o: expected %0b, actual %0b", test_name, exp, irq_o);
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin : main_seq
        addr_t addr;
        int    win;
        int    pick;
        int    steps;
        logic  drv_done;
        void'($urandom(37230));
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_write_i = 1'b0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b1;
        ext_irq_i   = '0;
        tmr_lvl     = '0;
        acc_cnt     = 0;
        rsp_cnt     = 0;
        checks      = 0;
        value_errs  = 0;
        other_errs  = 0;
        seen_full   = 1'b0;
        test_name   = "reset";
        model_reset();
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);
        checks += 2;
        if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0) begin
            value_errs++;
            $display("error reset ready/valid: expected 1/0, actual %b/%b",
                     req_ready_o, rsp_valid_o);
        end
        expect_irq(1'b0);

        test_name = "register access";
        single_access(plic_addr(OffThreshold), 1'b1, $urandom());
        single_access(plic_addr(OffThreshold), 1'b0, '0);
        for (int i = 0; i < NumSrc; i++) begin
            single_access(plic_addr(OffPrioBase + 4 * i), 1'b1, $urandom());
            single_access(plic_addr(OffPrioBase + 4 * i), 1'b0, '0);
        end
        for (int t = 0; t < NumTimers; t++) begin
            single_access(timer_addr(t, OffCompare), 1'b1, $urandom());
            single_access(timer_addr(t, OffCompare), 1'b0, '0);
        end

        test_name = "unmapped";
        // same offset as the threshold register, so a leaked write shows up
        for (int r = 2; r < 16; r++) begin
            addr = {region_t'(r), OffThreshold};
            single_access(addr, 1'b1, $urandom());
            single_access(addr, 1'b0, '0);
        end
        single_access(plic_addr(OffThreshold), 1'b0, '0);

        test_name = "timer irq";
        single_access(plic_addr(OffThreshold), 1'b1, 32'd0);
        single_access(plic_addr(OffPrioBase), 1'b1, 32'd3);
        single_access(plic_addr(OffEnable), 1'b1, 32'h1);
        single_access(timer_addr(0, OffCompare), 1'b1, 32'd5);
        single_access(timer_addr(0, OffCount), 1'b1, 32'd0);
        single_access(timer_addr(0, OffCtrl), 1'b1, 32'd1);
        wait_for_irq();
        tmr_lvl[0] = 1'b1;
        single_access(plic_addr(OffClaim), 1'b0, '0);
        expect_irq(1'b0);
        single_access(timer_addr(0, OffCtrl), 1'b1, 32'd0);
        tmr_lvl[0] = 1'b0;
        single_access(plic_addr(OffClaim), 1'b1, 32'd1);
        repeat (10) expect_irq(1'b0);

        test_name = "arbitration";
        single_access(plic_addr(OffEnable), 1'b1, 32'hc);
        for (int n = 0; n < 8; n++) begin
            for (int i = NumTimers; i < NumSrc; i++) begin
                single_access(plic_addr(OffPrioBase + 4 * i), 1'b1, $urandom());
            end
            @(negedge clk_i);
            ext_irq_i = NumExtIrq'($urandom());
            single_access(plic_addr(OffPending), 1'b0, '0);
            win = claim_winner({ext_irq_i, tmr_lvl});
            expect_irq(win != 0);
            single_access(plic_addr(OffClaim), 1'b0, '0);
            if (win != 0) begin
                single_access(plic_addr(OffClaim), 1'b1, data_t'(win));
            end
        end
        @(negedge clk_i);
        ext_irq_i = '1;
        // top priority sits exactly at the threshold
        single_access(plic_addr(OffPrioBase + 8), 1'b1, 32'd7);
        single_access(plic_addr(OffPrioBase + 12), 1'b1, 32'd7);
        single_access(plic_addr(OffThreshold), 1'b1, 32'd7);
        expect_irq(1'b0);
        single_access(plic_addr(OffClaim), 1'b0, '0);
        single_access(plic_addr(OffThreshold), 1'b1, 32'd0);

        test_name = "claim complete";
        single_access(plic_addr(OffPrioBase + 8), 1'b1, 32'd2);
        single_access(plic_addr(OffPrioBase + 12), 1'b1, 32'd5);
        repeat (3) single_access(plic_addr(OffClaim), 1'b0, '0);
        expect_irq(1'b0);
        single_access(plic_addr(OffClaim), 1'b1, 32'd4);
        single_access(plic_addr(OffClaim), 1'b0, '0);
        single_access(plic_addr(OffClaim), 1'b1, 32'd4);
        single_access(plic_addr(OffClaim), 1'b1, 32'd3);

        test_name = "back-pressure";
        @(negedge clk_i);
        ext_irq_i = 2'b01;
        drv_done  = 1'b0;
        steps     = 0;
        fork
            begin
                for (int n = 0; n < 40; n++) begin
                    pick = $urandom_range(0, 4);
                    case (pick)
                        0: send_req(plic_addr(OffThreshold), 1'($urandom()), $urandom());
                        1: send_req(plic_addr(OffPrioBase + 4 * $urandom_range(0, NumSrc - 1)),
                                    1'($urandom()), $urandom());
                        2: send_req(timer_addr($urandom_range(0, NumTimers - 1), OffCompare),
                                    1'($urandom()), $urandom());
                        3: send_req({region_t'($urandom_range(2, 15)), off_t'($urandom())},
                                    1'($urandom()), $urandom());
                        default: send_req(plic_addr(OffPending), 1'b0, '0);
                    endcase
                end
                drv_done = 1'b1;
            end
            begin
                while (!drv_done && steps < 400) begin
                    @(negedge clk_i);
                    rsp_ready_i = 1'b0;
                    repeat ($urandom_range(1, 6)) @(negedge clk_i);
                    rsp_ready_i = 1'b1;
                    repeat ($urandom_range(1, 3)) @(negedge clk_i);
                    steps++;
                end
            end
        join
        @(negedge clk_i);
        rsp_ready_i = 1'b1;
        wait_responses();
        checks++;
        if (!seen_full) begin
            other_errs++;
            $display("req_ready_o never fell under back-pressure");
        end

        print_summary();
        if (value_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* design/periph_top.sv */
`timescale 1ns/1ns

module periph_top
    import periph_pkg::*;
#(
    parameter int ReqDepth  = 2,
    parameter int NumTimers = 2,
    parameter int NumExtIrq = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  addr_t                req_addr_i,
    input  logic                 req_write_i,
    input  data_t                req_wdata_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output data_t                rsp_rdata_o,
    output logic                 rsp_err_o,
    input  logic [NumExtIrq-1:0] ext_irq_i,
    output logic                 irq_o
);

    localparam int NumSrc = NumTimers + NumExtIrq;

    logic  fifo_valid;
    logic  fifo_ready;
    addr_t fifo_addr;
    logic  fifo_write;
    data_t fifo_wdata;

    logic  timer_sel;
    logic  plic_sel;
    logic  bus_we;
    off_t  bus_offset;
    data_t bus_wdata;
    data_t timer_rdata;
    data_t plic_rdata;

    logic [NumTimers-1:0] tmr_irq;
    logic [NumSrc-1:0]    irq_src;

    // timers take the low source indices
    assign irq_src = {ext_irq_i, tmr_irq};

    periph_req_fifo #(
        .ReqDepth ( ReqDepth )
    ) periph_req_fifo_inst (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .in_valid_i  ( req_valid_i ),
        .in_ready_o  ( req_ready_o ),
        .in_addr_i   ( req_addr_i  ),
        .in_write_i  ( req_write_i ),
        .in_wdata_i  ( req_wdata_i ),
        .out_valid_o ( fifo_valid  ),
        .out_ready_i ( fifo_ready  ),
        .out_addr_o  ( fifo_addr   ),
        .out_write_o ( fifo_write  ),
        .out_wdata_o ( fifo_wdata  )
    );

    periph_decode periph_decode_inst (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .in_valid_i    ( fifo_valid  ),
        .in_ready_o    ( fifo_ready  ),
        .in_addr_i     ( fifo_addr   ),
        .in_write_i    ( fifo_write  ),
        .in_wdata_i    ( fifo_wdata  ),
        .timer_sel_o   ( timer_sel   ),
        .plic_sel_o    ( plic_sel    ),
        .we_o          ( bus_we      ),
        .offset_o      ( bus_offset  ),
        .wdata_o       ( bus_wdata   ),
        .timer_rdata_i ( timer_rdata ),
        .plic_rdata_i  ( plic_rdata  ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_ready_i   ( rsp_ready_i ),
        .rsp_rdata_o   ( rsp_rdata_o ),
        .rsp_err_o     ( rsp_err_o   )
    );

    periph_timer #(
        .NumTimers ( NumTimers )
    ) periph_timer_inst (
        .clk_i    ( clk_i       ),
        .rst_i    ( rst_i       ),
        .sel_i    ( timer_sel   ),
        .we_i     ( bus_we      ),
        .offset_i ( bus_offset  ),
        .wdata_i  ( bus_wdata   ),
        .rdata_o  ( timer_rdata ),
        .irq_o    ( tmr_irq     )
    );

    periph_plic #(
        .NumSrc ( NumSrc )
    ) periph_plic_inst (
        .clk_i    ( clk_i      ),
        .rst_i    ( rst_i      ),
        .sel_i    ( plic_sel   ),
        .we_i     ( bus_we     ),
        .offset_i ( bus_offset ),
        .wdata_i  ( bus_wdata  ),
        .rdata_o  ( plic_rdata ),
        .src_i    ( irq_src    ),
        .irq_o    ( irq_o      )
    );

endmodule

/* design/periph_plic.sv */
`timescale 1ns/1ns

module periph_plic
    import periph_pkg::*;
#(
    parameter int NumSrc = 4
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              sel_i,
    input  logic              we_i,
    input  off_t              offset_i,
    input  data_t             wdata_i,
    output data_t             rdata_o,
    input  logic [NumSrc-1:0] src_i,
    output logic              irq_o
);

    localparam int IdxWidth = (NumSrc > 1) ? $clog2(NumSrc) : 1;
    localparam int IdWidth  = $clog2(NumSrc + 1);

    prio_t             prio_q [NumSrc];
    logic [NumSrc-1:0] enable_q;
    prio_t             threshold_q;
    logic [NumSrc-1:0] in_service_q;

    logic [NumSrc-1:0]   eligible;
    prio_t               best_prio;
    logic [IdxWidth-1:0] best_idx;
    logic [IdWidth-1:0]  claim_id;
    logic                wr_en;
    logic                claim_rd;
    logic                complete_wr;

    assign wr_en       = sel_i && we_i;
    assign claim_rd    = sel_i && !we_i && (offset_i == OffClaim);
    assign complete_wr = wr_en && (offset_i == OffClaim);

    // ----------------------------------------
    // eligibility and arbitration
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            eligible[i] = src_i[i] && enable_q[i] && !in_service_q[i]
                          && (prio_q[i] > threshold_q);
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_prio = '0;
        best_idx  = '0;
        for (int i = 0; i < NumSrc; i++) begin
            if (eligible[i] && prio_q[i] > best_prio) begin
                best_prio = prio_q[i];
                best_idx  = IdxWidth'(i);
            end
        end
    end

    assign irq_o    = |eligible;
    assign claim_id = irq_o ? IdWidth'(best_idx) + 1'b1 : '0;

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q     <= '0;
            threshold_q  <= '0;
            in_service_q <= '0;
            for (int i = 0; i < NumSrc; i++) begin
                prio_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumSrc; i++) begin
                if (wr_en && offset_i == off_t'(OffPrioBase + 4 * i)) begin
                    prio_q[i] <= wdata_i[PrioWidth-1:0];
                end
                if (claim_rd && irq_o && best_idx == IdxWidth'(i)) begin
                    in_service_q[i] <= 1'b1;
                end else if (complete_wr && wdata_i == data_t'(i + 1)) begin
                    in_service_q[i] <= 1'b0;
                end
            end
            if (wr_en && offset_i == OffEnable) begin
                enable_q <= wdata_i[NumSrc-1:0];
            end
            if (wr_en && offset_i == OffThreshold) begin
                threshold_q <= wdata_i[PrioWidth-1:0];
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NumSrc; i++) begin
            if (offset_i == off_t'(OffPrioBase + 4 * i)) begin
                rdata_o = data_t'(prio_q[i]);
            end
        end
        case (offset_i)
            OffPending:   rdata_o = data_t'(src_i);
            OffEnable:    rdata_o = data_t'(enable_q);
            OffThreshold: rdata_o = data_t'(threshold_q);
            OffClaim:     rdata_o = data_t'(claim_id);
            default:      ;
        endcase
    end

endmodule

/* design/periph_timer.sv */
`timescale 1ns/1ns

module periph_timer
    import periph_pkg::*;
#(
    parameter int NumTimers = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 sel_i,
    input  logic                 we_i,
    input  off_t                 offset_i,
    input  data_t                wdata_i,
    output data_t                rdata_o,
    output logic [NumTimers-1:0] irq_o
);

    localparam int StrideBits = $clog2(TimerStride);

    logic [OffWidth-StrideBits-1:0] grp;
    logic [StrideBits-1:0]          word;
    logic                           wr_en;

    logic [NumTimers-1:0] en_q;
    data_t                count_q [NumTimers];
    data_t                cmp_q   [NumTimers];

    // group index and register within the group
    assign grp   = offset_i[OffWidth-1:StrideBits];
    assign word  = offset_i[StrideBits-1:0];
    assign wr_en = sel_i && we_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q <= '0;
            for (int i = 0; i < NumTimers; i++) begin
                count_q[i] <= '0;
                cmp_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < NumTimers; i++) begin
                if (wr_en && grp == i && word == StrideBits'(OffCtrl)) begin
                    en_q[i] <= wdata_i[0];
                end
                // software write wins over the increment
                if (wr_en && grp == i && word == StrideBits'(OffCount)) begin
                    count_q[i] <= wdata_i;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
                if (wr_en && grp == i && word == StrideBits'(OffCompare)) begin
                    cmp_q[i] <= wdata_i;
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NumTimers; i++) begin
            if (grp == i) begin
                case (word)
                    StrideBits'(OffCtrl):    rdata_o = data_t'(en_q[i]);
                    StrideBits'(OffCount):   rdata_o = count_q[i];
                    StrideBits'(OffCompare): rdata_o = cmp_q[i];
                    default:                 rdata_o = '0;
                endcase
            end
        end
    end

    // level interrupt per timer
    always_comb begin
        for (int i = 0; i < NumTimers; i++) begin
            irq_o[i] = en_q[i] && (count_q[i] >= cmp_q[i]);
        end
    end

endmodule

/* design/periph_decode.sv */
`timescale 1ns/1ns

module periph_decode
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  in_valid_i,
    output logic  in_ready_o,
    input  addr_t in_addr_i,
    input  logic  in_write_i,
    input  data_t in_wdata_i,
    output logic  timer_sel_o,
    output logic  plic_sel_o,
    output logic  we_o,
    output off_t  offset_o,
    output data_t wdata_o,
    input  data_t timer_rdata_i,
    input  data_t plic_rdata_i,
    output logic  rsp_valid_o,
    input  logic  rsp_ready_i,
    output data_t rsp_rdata_o,
    output logic  rsp_err_o
);

    region_t region;
    logic    hit_timer;
    logic    hit_plic;
    logic    pop;
    data_t   rdata_d;

    logic    rsp_valid_q;
    data_t   rsp_rdata_q;
    logic    rsp_err_q;

    // ----------------------------------------
    // region decode
    // ----------------------------------------
    assign region    = in_addr_i[AddrWidth-1:OffWidth];
    assign hit_timer = (region == RegionTimer);
    assign hit_plic  = (region == RegionPlic);

    // pop when the response slot is free or draining this cycle
    assign in_ready_o = !rsp_valid_q || rsp_ready_i;
    assign pop        = in_valid_i && in_ready_o;

    // unmapped accesses strobe nobody
    assign timer_sel_o = pop && hit_timer;
    assign plic_sel_o  = pop && hit_plic;
    assign we_o        = in_write_i;
    assign offset_o    = in_addr_i[OffWidth-1:0];
    assign wdata_o     = in_wdata_i;

    always_comb begin
        if (!hit_timer && !hit_plic) begin
            rdata_d = ErrData;
        end else if (in_write_i) begin
            rdata_d = '0;
        end else if (hit_timer) begin
            rdata_d = timer_rdata_i;
        end else begin
            rdata_d = plic_rdata_i;
        end
    end

    // ----------------------------------------
    // response register
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
        end else if (pop) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            rsp_rdata_q <= rdata_d;
            rsp_err_q   <= !hit_timer && !hit_plic;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_err_o   = rsp_err_q;

endmodule

/* design/periph_req_fifo.sv */
`timescale 1ns/1ns

module periph_req_fifo
    import periph_pkg::*;
#(
    parameter int ReqDepth = 2
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  in_valid_i,
    output logic  in_ready_o,
    input  addr_t in_addr_i,
    input  logic  in_write_i,
    input  data_t in_wdata_i,
    output logic  out_valid_o,
    input  logic  out_ready_i,
    output addr_t out_addr_o,
    output logic  out_write_o,
    output data_t out_wdata_o
);

    localparam int PtrWidth = (ReqDepth > 1) ? $clog2(ReqDepth) : 1;
    localparam int CntWidth = $clog2(ReqDepth + 1);

    addr_t addr_mem  [ReqDepth];
    logic  write_mem [ReqDepth];
    data_t wdata_mem [ReqDepth];

    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                full;
    logic                push;
    logic                pop;

    assign full        = (count_q == CntWidth'(ReqDepth));
    // a full buffer still takes a new entry when the head leaves
    assign in_ready_o  = !full || out_ready_i;
    assign out_valid_o = (count_q != '0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    assign out_addr_o  = addr_mem[rd_ptr_q];
    assign out_write_o = write_mem[rd_ptr_q];
    assign out_wdata_o = wdata_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q]  <= in_addr_i;
            write_mem[wr_ptr_q] <= in_write_i;
            wdata_mem[wr_ptr_q] <= in_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(ReqDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(ReqDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* design/periph_pkg.sv */
package periph_pkg;

    // ----------------------------------------
    // bus widths and types
    // ----------------------------------------
    localparam int AddrWidth = 16;
    localparam int DataWidth = 32;
    localparam int PrioWidth = 3;
    localparam int OffWidth  = 12;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [PrioWidth-1:0] prio_t;
    typedef logic [OffWidth-1:0]  off_t;
    typedef logic [AddrWidth-OffWidth-1:0] region_t;

    // region code sits in the top address nibble
    localparam region_t RegionPlic  = 4'h0;
    localparam region_t RegionTimer = 4'h1;

    // ----------------------------------------
    // register map
    // ----------------------------------------
    localparam off_t OffPrioBase  = 12'h000;
    localparam off_t OffPending   = 12'h080;
    localparam off_t OffEnable    = 12'h100;
    localparam off_t OffThreshold = 12'h200;
    localparam off_t OffClaim     = 12'h204;

    localparam int   TimerStride = 16;
    localparam off_t OffCtrl     = 12'h000;
    localparam off_t OffCount    = 12'h004;
    localparam off_t OffCompare  = 12'h008;

    // read data for unmapped regions
    localparam data_t ErrData = 32'hDEAD_BEEF;

endpackage
